// ==== ptg_trace.txt ====
# M byte_addr data | E byte_addr (read answers SLVERR) | R asid miss_adr exp_pte found err
# All fields hex, the last six R records are sent back to back with resp_ready held low
M 00010000 222222f3
M 00010004 800e0080
M 00010008 244444a5
M 0001000c 000a0080
M 00010010 22468bc3
M 00010014 800a0080
M 00010018 2a864200
M 0001001c c7fe0080
M 00010020 00180007
M 00010024 a00a0100
M 00010040 00000200
M 00010044 e0000080
E 00010048
R 005 00401000 800a008022468bc3 1 0
R 0ab 00401000 c7fe00802a864200 1 0
R 005 00bc2000 a00a010000180007 1 0
R 005 00441000 0000000000000000 0 0
R 005 00400000 0000000000000000 0 1
R 005 00401000 800a008022468bc3 1 0
R 0ab 00bc2000 0000000000000000 0 0
R 005 00400000 0000000000000000 0 1
R 0ab 00401000 c7fe00802a864200 1 0
R 005 00bc2000 a00a010000180007 1 0
R 005 00441000 0000000000000000 0 0

// ==== list.f ====
mmu_pkg.sv
stream_if.sv
stream_fifo.sv
ptg_fetch.sv
ptg_search.sv
ptg_walker_top.sv
ptg_walker_chk.sv
tb_scoreboard.sv
tb_ptg_walker.sv

// ==== tb_ptg_walker.sv ====
// Testbench for the PTG walker with trace-driven requests and an AXI4-Lite memory model
`timescale 1ns/1ps
`default_nettype none

module tb_ptg_walker import mmu_pkg::*; ();

	// Last requests of the trace go back to back under a stalled result port
	localparam int BURST_LEN = 6;
	localparam int HOLD_CYCLES = 40;
	localparam int RESET_CYCLES = 5;

	logic        clk = 1'b0;
	logic        rst;
	logic        req_valid;
	logic        req_ready;
	logic [11:0] req_asid;
	logic [31:0] req_adr;
	logic [31:0] m_araddr;
	logic        m_arvalid;
	logic        m_arready;
	logic [31:0] m_rdata;
	logic [1:0]  m_rresp;
	logic        m_rvalid;
	logic        m_rready;
	logic        resp_valid;
	logic        resp_ready = 1'b0;
	logic [63:0] resp_pte;
	logic        resp_found;
	logic        resp_err;

	int          n_done;
	int          n_fail;
	int          n_req = 0;
	int          cycle_cnt = 0;
	int          limit = 0;
	int          hold_until = 0;
	logic        burst_wait = 1'b0;
	logic [31:0] lfsr = 32'h573ffd37;

	// Memory image and the words that answer with SLVERR
	logic [31:0] mem_data [logic [31:0]];
	bit          err_word [logic [31:0]];
	// Requests and their expected results in trace order
	logic [11:0] t_asid [$];
	logic [31:0] t_adr [$];
	logic [63:0] t_pte [$];
	logic        t_found [$];
	logic        t_err [$];

	always #20 clk = ~clk;

	ptg_walker_top DUT (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_asid   (req_asid),
		.req_adr    (req_adr),
		.m_araddr   (m_araddr),
		.m_arvalid  (m_arvalid),
		.m_arready  (m_arready),
		.m_rdata    (m_rdata),
		.m_rresp    (m_rresp),
		.m_rvalid   (m_rvalid),
		.m_rready   (m_rready),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_pte   (resp_pte),
		.resp_found (resp_found),
		.resp_err   (resp_err)
	);

	tb_scoreboard sb (
		.clk        (clk),
		.rst        (rst),
		.resp_valid (resp_valid),
		.resp_ready (resp_ready),
		.resp_pte   (resp_pte),
		.resp_found (resp_found),
		.resp_err   (resp_err),
		.n_done     (n_done),
		.n_fail     (n_fail)
	);

	// ===================================================================
	// Helpers
	// ===================================================================

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// Unlisted words keep bit 31 clear, so their entries are never valid
	function automatic logic [31:0] fill_word(input logic [31:0] adr);
		return {1'b0, adr[31] ^ adr[30], adr[29:0]};
	endfunction

	// Two bits per draw give a wait of zero to three cycles
	task automatic draw_wait(output int w);
		w = 0;
		repeat (2) begin
			lfsr = lfsr_step(lfsr);
			w = (w << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic read_trace(output bit ok);
		int          fd;
		int          code;
		logic [63:0] tag;
		logic [8*160-1:0] line;
		logic [31:0] a;
		logic [31:0] d;
		logic [11:0] asid;
		logic [63:0] pte;
		logic        found;
		logic        err;
		ok = 1'b1;
		fd = $fopen("ptg_trace.txt", "r");
		if (fd == 0) begin
			ok = 1'b0;
		end else begin
			while (ok && $fscanf(fd, "%s", tag) == 1) begin
				if (tag == "#") begin
					code = $fgets(line, fd);
				end else if (tag == "M") begin
					code = $fscanf(fd, "%h %h", a, d);
					ok = (code == 2);
					mem_data[a] = d;
				end else if (tag == "E") begin
					code = $fscanf(fd, "%h", a);
					ok = (code == 1);
					err_word[a] = 1'b1;
				end else if (tag == "R") begin
					code = $fscanf(fd, "%h %h %h %h %h", asid, a, pte, found, err);
					ok = (code == 5);
					t_asid.push_back(asid);
					t_adr.push_back(a);
					t_pte.push_back(pte);
					t_found.push_back(found);
					t_err.push_back(err);
				end else begin
					ok = 1'b0;
				end
			end
			$fclose(fd);
		end
	endtask

	// Holds the request until an edge sees req_ready high
	task automatic send_request(input logic [11:0] asid, input logic [31:0] adr);
		logic taken;
		req_valid = 1'b1;
		req_asid = asid;
		req_adr = adr;
		taken = 1'b0;
		while (!taken) begin
			taken = (req_ready === 1'b1);
			@(posedge clk);
			#2;
		end
	endtask

	// ===================================================================
	// AXI4-Lite memory model
	// ===================================================================

	initial begin : axi_memory
		int          w;
		logic [31:0] adr;
		logic        taken;
		m_arready = 1'b0;
		m_rvalid = 1'b0;
		m_rdata = '0;
		m_rresp = '0;
		@(posedge clk);
		#2;
		forever begin
			if (rst || m_arvalid !== 1'b1) begin
				@(posedge clk);
				#2;
			end else begin
				draw_wait(w);
				repeat (w) begin
					@(posedge clk);
					#2;
				end
				adr = m_araddr;
				m_arready = 1'b1;
				@(posedge clk);
				#2;
				m_arready = 1'b0;
				draw_wait(w);
				repeat (w) begin
					@(posedge clk);
					#2;
				end
				m_rdata = mem_data.exists(adr) ? mem_data[adr] : fill_word(adr);
				m_rresp = err_word.exists(adr) ? 2'b10 : axi_resp_okay;
				m_rvalid = 1'b1;
				// The beat stays offered until an edge sees rready high
				taken = 1'b0;
				while (!taken) begin
					taken = (m_rready === 1'b1);
					@(posedge clk);
					#2;
				end
				m_rvalid = 1'b0;
			end
		end
	end

	// ===================================================================
	// Result back-pressure and timeout
	// ===================================================================

	// The result port stalls from the start of the burst until forty cycles
	// after the first burst result is offered
	always @(posedge clk) begin
		#2;
		if (burst_wait && resp_valid === 1'b1) begin
			burst_wait = 1'b0;
			hold_until = cycle_cnt + HOLD_CYCLES;
		end
		resp_ready = !burst_wait && (cycle_cnt >= hold_until);
	end

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (limit > 0 && cycle_cnt >= limit) begin
			$display("timeout after %0d cycles with %0d of %0d results seen", limit, n_done, n_req);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// ===================================================================
	// Stimulus
	// ===================================================================

	initial begin : main
		bit ok;
		rst = 1'b1;
		req_valid = 1'b0;
		req_asid = '0;
		req_adr = '0;
		read_trace(ok);
		n_req = t_asid.size();
		if (!ok || n_req < BURST_LEN) begin
			$display("trace file ptg_trace.txt is missing or malformed");
			$display("*** FAILED ***");
			$finish;
		end else begin
			// Worst case is eight cycles per bus word plus pipeline overhead
			limit = n_req * (WORDS_PER_PTG * 8 + 10);
			repeat (RESET_CYCLES) @(posedge clk);
			#2;
			rst = 1'b0;
			for (int i = 0; i < n_req; i++) begin
				if (i == n_req - BURST_LEN)
					burst_wait = 1'b1;
				sb.expect_result(t_pte[i], t_found[i], t_err[i]);
				send_request(t_asid[i], t_adr[i]);
				// Single requests wait for their own result before the next one
				if (i < n_req - BURST_LEN) begin
					req_valid = 1'b0;
					while (n_done <= i) begin
						@(posedge clk);
						#2;
					end
				end
			end
			req_valid = 1'b0;
			while (n_done < n_req) begin
				@(posedge clk);
				#2;
			end
			sb.report_totals();
			if (n_fail == 0 && DUT.u_chk.n_errors == 0)
				$display("*** PASSED ***");
			else
				$display("*** FAILED ***");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== tb_scoreboard.sv ====
// Result scoreboard comparing walker responses with expected values in request order
`timescale 1ns/1ps
`default_nettype none

module tb_scoreboard (
	input  wire        clk,
	input  wire        rst,
	input  wire        resp_valid,
	input  wire        resp_ready,
	input  wire [63:0] resp_pte,
	input  wire        resp_found,
	input  wire        resp_err,
	output int         n_done,
	output int         n_fail
);

	// Expected results, oldest request at the front
	logic [63:0] exp_pte [$];
	logic        exp_found [$];
	logic        exp_err [$];

	task automatic expect_result(input logic [63:0] pte, input logic found, input logic err);
		exp_pte.push_back(pte);
		exp_found.push_back(found);
		exp_err.push_back(err);
	endtask

	task automatic report_totals();
		$display("results checked %0d, passed %0d, failed %0d", n_done, n_done - n_fail, n_fail);
	endtask

	initial begin
		n_done = 0;
		n_fail = 0;
	end

	// Sampled on the falling edge, where valid and ready show the transfer
	// that the coming rising edge completes
	always @(negedge clk) begin
		logic        bad;
		logic [63:0] e_pte;
		logic        e_found;
		logic        e_err;
		if (!rst && resp_valid === 1'b1 && resp_ready === 1'b1) begin
			if (exp_pte.size() == 0) begin
				$display("result arrived with no request outstanding");
				n_fail = n_fail + 1;
			end else begin
				e_pte = exp_pte.pop_front();
				e_found = exp_found.pop_front();
				e_err = exp_err.pop_front();
				bad = 1'b0;
				if (resp_pte !== e_pte) begin
					$display("FAIL test %0d resp_pte exp %h got %h", n_done + 1, e_pte, resp_pte);
					bad = 1'b1;
				end
				if (resp_found !== e_found) begin
					$display("FAIL test %0d resp_found exp %h got %h", n_done + 1, e_found,
						resp_found);
					bad = 1'b1;
				end
				if (resp_err !== e_err) begin
					$display("FAIL test %0d resp_err exp %h got %h", n_done + 1, e_err, resp_err);
					bad = 1'b1;
				end
				if (bad)
					n_fail = n_fail + 1;
				else
					$display("ok   test %0d pte %h found %0d err %0d", n_done + 1, resp_pte,
						resp_found, resp_err);
				n_done = n_done + 1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== ptg_walker_chk.sv ====
// Protocol checker for the walker's AXI4-Lite read port and result stream
`timescale 1ns/1ps
`default_nettype none

module ptg_walker_chk (
	input wire        clk,
	input wire        rst,
	input wire        m_arvalid,
	input wire        m_arready,
	input wire [31:0] m_araddr,
	input wire        m_rready,
	input wire        req_ready,
	input wire        resp_valid,
	input wire        resp_ready
);

	// Tally of failed assertions, looked at by the testbench at the end
	int n_errors = 0;

	// ===================================================================
	// AXI4-Lite read address and data rules
	// ===================================================================

	// A stalled address phase keeps both valid and address steady
	a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
	else begin
		n_errors++;
		$error("read address changed or arvalid dropped before arready");
	end

	// Once the address is taken the read is pending and rready must be up
	a_rready_pending: assert property (@(posedge clk) disable iff (rst)
		m_arvalid && m_arready |=> m_rready)
	else begin
		n_errors++;
		$error("rready low while a read is pending");
	end

	// ===================================================================
	// Result stream rules
	// ===================================================================

	a_resp_hold: assert property (@(posedge clk) disable iff (rst)
		resp_valid && !resp_ready |=> resp_valid)
	else begin
		n_errors++;
		$error("resp_valid fell without a transfer");
	end

	a_no_x_valid: assert property (@(posedge clk) disable iff (rst)
		!$isunknown({m_arvalid, m_rready, req_ready, resp_valid}))
	else begin
		n_errors++;
		$error("unknown value on a valid or ready output after reset");
	end

endmodule

bind ptg_walker_top ptg_walker_chk u_chk (
	.clk        (clk),
	.rst        (rst),
	.m_arvalid  (m_arvalid),
	.m_arready  (m_arready),
	.m_araddr   (m_araddr),
	.m_rready   (m_rready),
	.req_ready  (req_ready),
	.resp_valid (resp_valid),
	.resp_ready (resp_ready)
);

`default_nettype wire

// ==== ptg_walker_top.sv ====
// PTG walker top level joining request FIFO, fetch, search and result FIFO
`timescale 1ns/1ps
`default_nettype none

module ptg_walker_top import mmu_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	// Miss requests from the TLB
	input  wire         req_valid,
	output logic        req_ready,
	input  wire  [11:0] req_asid,
	input  wire  [31:0] req_adr,
	// AXI4-Lite read channels toward memory
	output logic [31:0] m_araddr,
	output logic        m_arvalid,
	input  wire         m_arready,
	input  wire  [31:0] m_rdata,
	input  wire  [1:0]  m_rresp,
	input  wire         m_rvalid,
	output logic        m_rready,
	// Walk results back to the TLB
	output logic        resp_valid,
	input  wire         resp_ready,
	output pte_t        resp_pte,
	output logic        resp_found,
	output logic        resp_err
);

	// ===================================================================
	// Internal streams
	// ===================================================================

	stream_if #(.T(miss_req_t))    req_in ();
	stream_if #(.T(miss_req_t))    req_q ();
	stream_if #(.T(fetch_t))       fetched ();
	stream_if #(.T(walk_result_t)) result ();
	stream_if #(.T(walk_result_t)) resp_q ();

	// Request ports map straight onto the input stream
	assign req_in.valid = req_valid;
	assign req_in.data = '{asid: req_asid, miss_adr: req_adr};
	assign req_ready = req_in.ready;

	// Result ports are unpacked from the output stream
	assign resp_valid = resp_q.valid;
	assign resp_pte = resp_q.data.pte;
	assign resp_found = resp_q.data.found;
	assign resp_err = resp_q.data.err;
	assign resp_q.ready = resp_ready;

	// ===================================================================
	// Pipeline
	// ===================================================================

	stream_fifo #(.T(miss_req_t)) u_req_fifo (
		.clk   (clk),
		.rst   (rst),
		.in_s  (req_in.sink),
		.out_s (req_q.source)
	);

	ptg_fetch u_fetch (
		.clk       (clk),
		.rst       (rst),
		.req       (req_q.sink),
		.ptg_out   (fetched.source),
		.m_araddr  (m_araddr),
		.m_arvalid (m_arvalid),
		.m_arready (m_arready),
		.m_rdata   (m_rdata),
		.m_rresp   (m_rresp),
		.m_rvalid  (m_rvalid),
		.m_rready  (m_rready)
	);

	ptg_search u_search (
		.clk     (clk),
		.rst     (rst),
		.ptg_in  (fetched.sink),
		.res_out (result.source)
	);

	// Back-pressure from resp_ready first fills this FIFO, then stalls search
	stream_fifo #(.T(walk_result_t)) u_resp_fifo (
		.clk   (clk),
		.rst   (rst),
		.in_s  (result.sink),
		.out_s (resp_q.source)
	);

endmodule

`default_nettype wire

// ==== ptg_search.sv ====
// PTG search stage that picks the first matching entry and registers the result
`timescale 1ns/1ps
`default_nettype none

module ptg_search import mmu_pkg::*; (
	input  wire      clk,
	input  wire      rst,
	stream_if.sink   ptg_in,
	stream_if.source res_out
);

	miss_req_t    rq;
	ptg_t         ptg;
	logic         bus_err;
	logic         hit;
	pte_t         hit_pte;
	walk_result_t res_d;
	walk_result_t res_r;
	logic         res_valid;

	assign rq = ptg_in.data.req;
	assign ptg = ptg_in.data.ptg;
	assign bus_err = ptg_in.data.bus_err;

	// ===================================================================
	// Combinational priority search
	// ===================================================================

	// Entry 0 has the highest priority, later hits are ignored
	always_comb begin
		hit = 1'b0;
		hit_pte = '0;
		for (int k = 0; k < PTE_PER_PTG; k++) begin
			if (!hit && ptg[k].v && ptg[k].vpn[19:10] == rq.miss_adr[31:22]
				&& (ptg[k].s || ptg[k].vpn[9:0] == rq.miss_adr[21:12])
				&& (ptg[k].g || ptg[k].asid == rq.asid)) begin
				hit = 1'b1;
				hit_pte = ptg[k];
			end
		end
	end

	// A bus error overrides whatever the search found
	assign res_d = '{pte: bus_err ? '0 : hit_pte, found: hit && !bus_err, err: bus_err};

	// ===================================================================
	// Result register
	// ===================================================================

	// Accept a group when the register is empty or drains on this edge
	assign ptg_in.ready = !res_valid || res_out.ready;
	assign res_out.valid = res_valid;
	assign res_out.data = res_r;

	always_ff @(posedge clk) begin
		if (rst)
			res_valid <= 1'b0;
		else if (ptg_in.valid && ptg_in.ready)
			res_valid <= 1'b1;
		else if (res_out.ready)
			res_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ptg_in.valid && ptg_in.ready)
			res_r <= res_d;
	end

endmodule

`default_nettype wire

// ==== ptg_fetch.sv ====
// PTG fetch unit that hashes the miss address and reads one group over AXI4-Lite
`timescale 1ns/1ps
`default_nettype none

module ptg_fetch import mmu_pkg::*; (
	input  wire         clk,
	input  wire         rst,
	stream_if.sink      req,
	stream_if.source    ptg_out,
	output logic [31:0] m_araddr,
	output logic        m_arvalid,
	input  wire         m_arready,
	input  wire  [31:0] m_rdata,
	input  wire  [1:0]  m_rresp,
	input  wire         m_rvalid,
	output logic        m_rready
);

	// Idle waits for a miss, address issues one read, data waits for its beat
	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data
	} fetch_state_t;

	fetch_state_t                     state;
	logic [WORD_IDX_BITS-1:0]         word_cnt;
	logic                             out_valid;
	logic                             last_word;

	// Request, group base and gathered words for the walk in progress
	miss_req_t                        req_r;
	logic [31:0]                      ptg_adr;
	logic [WORDS_PER_PTG*32-1:0]      ptg_words;
	logic                             bus_err;

	// ===================================================================
	// Stream and bus outputs
	// ===================================================================

	// New misses are taken only once the previous group has been handed on
	assign req.ready = (state == st_idle) && !out_valid;

	assign ptg_out.valid = out_valid;
	assign ptg_out.data = '{req: req_r, ptg: ptg_t'(ptg_words), bus_err: bus_err};

	// Word addresses climb by four bytes from the group base
	assign m_araddr = ptg_adr + {26'd0, word_cnt, 2'b00};
	// Only one read is ever outstanding since these two states exclude each other
	assign m_arvalid = (state == st_addr);
	assign m_rready = (state == st_data);

	assign last_word = (word_cnt == WORD_IDX_BITS'(WORDS_PER_PTG - 1));

	// ===================================================================
	// Control state machine
	// ===================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			word_cnt <= '0;
			out_valid <= 1'b0;
		end else begin
			// The finished group leaves when search accepts it
			if (out_valid && ptg_out.ready)
				out_valid <= 1'b0;
			case (state)
			st_idle:
				if (req.valid && req.ready) begin
					word_cnt <= '0;
					state <= st_addr;
				end
			st_addr:
				if (m_arready)
					state <= st_data;
			st_data:
				if (m_rvalid) begin
					if (last_word) begin
						out_valid <= 1'b1;
						state <= st_idle;
					end else begin
						word_cnt <= word_cnt + 1'b1;
						state <= st_addr;
					end
				end
			default:
				state <= st_idle;
			endcase
		end
	end

	// ===================================================================
	// Payload capture
	// ===================================================================

	always_ff @(posedge clk) begin
		if (state == st_idle && req.valid && req.ready) begin
			req_r <= req.data;
			ptg_adr <= PT_BASE + (32'(ptg_index(req.data.miss_adr)) << PTG_BYTE_BITS);
			bus_err <= 1'b0;
		end else if (state == st_data && m_rvalid) begin
			// Words shift in from the top, so word 0 ends up in the lowest slot
			ptg_words <= {m_rdata, ptg_words[WORDS_PER_PTG*32-1:32]};
			// Any failing beat poisons the whole group
			if (m_rresp != axi_resp_okay)
				bus_err <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== stream_fifo.sv ====
// Two-entry valid/ready FIFO with a type parameter for the payload it buffers
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
	parameter type T = logic
) (
	input  wire     clk,
	input  wire     rst,
	stream_if.sink   in_s,
	stream_if.source out_s
);

	// Two payload slots used as a circular buffer
	T           mem [0:1];
	logic       wr_ptr;
	logic       rd_ptr;
	// Number of slots holding data, from zero to two
	logic [1:0] count;
	logic       push;
	logic       pop;

	// ===================================================================
	// Handshake decode
	// ===================================================================

	// Ready depends on the held count alone, never on the output side
	assign in_s.ready = (count != 2'd2);
	// Valid is a decode of the count register, so it changes only on edges
	assign out_s.valid = (count != 2'd0);
	assign out_s.data = mem[rd_ptr];

	assign push = in_s.valid & in_s.ready;
	assign pop = out_s.valid & out_s.ready;

	// ===================================================================
	// Pointers and count
	// ===================================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;
			// A push and a pop on the same edge leave the count as it is
			if (push && !pop)
				count <= count + 2'd1;
			else if (pop && !push)
				count <= count - 2'd1;
		end
	end

	// Storage itself is written only on a push
	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_s.data;
	end

endmodule

`default_nettype wire

// ==== stream_if.sv ====
// Valid/ready stream interface carrying a payload of any packed type
`timescale 1ns/1ps
`default_nettype none

interface stream_if #(
	parameter type T = logic
);

	// A transfer takes place on a clock edge with valid and ready both high
	logic valid;
	logic ready;
	// Payload must hold steady from the raising of valid until the transfer
	T     data;

	// The producing side
	modport source (output valid, output data, input ready);
	// The consuming side
	modport sink (input valid, input data, output ready);

endinterface

`default_nettype wire

// ==== mmu_pkg.sv ====
// MMU walker package holding the page table entry, group and stream payload types
`default_nettype none

package mmu_pkg;

	// ===================================================================
	// Walker constants
	// ===================================================================

	// Eight entries of two bus words each make up one group
	localparam int PTE_PER_PTG = 8;
	localparam int WORDS_PER_PTG = 16;
	// Width of the word counter that walks through one group
	localparam int WORD_IDX_BITS = 4;
	localparam int PTG_INDEX_BITS = 6;
	// Each group spans 64 bytes, so the index is shifted up by six bits
	localparam int PTG_BYTE_BITS = 6;
	localparam logic [31:0] PT_BASE = 32'h0001_0000;
	localparam logic [1:0] axi_resp_okay = 2'b00;

	// ===================================================================
	// Page table types
	// ===================================================================

	// One page table entry, valid bit at the very top of the high word
	typedef struct packed {
		logic        v;
		logic        g;
		logic        s;
		logic [11:0] asid;
		logic [19:0] vpn;
		logic [19:0] ppn;
		logic [8:0]  attr;
	} pte_t;

	// Entry k occupies bus words 2k and 2k+1 of the group
	typedef pte_t [PTE_PER_PTG-1:0] ptg_t;

	// A TLB miss as it enters the walker
	typedef struct packed {
		logic [11:0] asid;
		logic [31:0] miss_adr;
	} miss_req_t;

	// Group contents handed from fetch to search, with the request that caused them
	typedef struct packed {
		miss_req_t req;
		ptg_t      ptg;
		logic      bus_err;
	} fetch_t;

	// Outcome of one walk
	typedef struct packed {
		pte_t pte;
		logic found;
		logic err;
	} walk_result_t;

	// Primary hash of the virtual page number
	function automatic logic [PTG_INDEX_BITS-1:0] ptg_index(input logic [31:0] miss_adr);
		return miss_adr[27:22] ^ miss_adr[17:12];
	endfunction

endpackage

`default_nettype wire
